//--- ce_params.svh
`ifndef CE_PARAMS_SVH
`define CE_PARAMS_SVH

// operand and result width, signed q8.8.
`define CE_DATA_W 16

// fraction bits of the fixed-point format.
`define CE_FRAC_W 8

// register stages between the operands and the stage-two input.
`define CE_S1_DEPTH 2

// width of the tag that travels with each item.
`define CE_TAG_W 4

`endif

//--- ce_pkg.sv
`include "ce_params.svh"

package ce_pkg;

  typedef logic signed [`CE_DATA_W-1:0]   data_t;
  typedef logic signed [2*`CE_DATA_W-1:0] wide_t;  // holds a full product.
  typedef logic [`CE_TAG_W-1:0]           tag_t;

  typedef enum logic [1:0] {
    OP1_FMA    = 2'd0,
    OP1_MUL    = 2'd1,
    OP1_ADD    = 2'd2,
    OP1_MINMAX = 2'd3
  } op1_e;

  typedef enum logic {
    OP2_NONE   = 1'b0,
    OP2_MINMAX = 1'b1
  } op2_e;

  // what rides beside an item through stage one.
  typedef struct packed {
    tag_t  tag;
    op2_e  op2;
    logic  op2_mod;
    data_t bias;
  } side_t;

  typedef struct packed {
    data_t result;
    tag_t  tag;
  } out_t;

  localparam data_t DATA_MAX = {1'b0, {(`CE_DATA_W-1){1'b1}}};
  localparam data_t DATA_MIN = {1'b1, {(`CE_DATA_W-1){1'b0}}};

  // clamp to the representable range.
  function automatic data_t sat_data(input wide_t v);
    if (v > wide_t'(DATA_MAX)) return DATA_MAX;
    if (v < wide_t'(DATA_MIN)) return DATA_MIN;
    return data_t'(v);
  endfunction

  // mode 0 picks the minimum, mode 1 the maximum.
  function automatic data_t min_max(input data_t a, input data_t b, input logic max_sel);
    if (max_sel) return (a > b) ? a : b;
    return (a < b) ? a : b;
  endfunction

endpackage

//--- ce_stage_if.sv
interface ce_stage_if;

  logic          valid;    // one-cycle qualifier per item.
  ce_pkg::data_t result;   // saturated stage-one result.
  ce_pkg::tag_t  tag;
  ce_pkg::op2_e  op2;
  logic          op2_mod;
  ce_pkg::data_t bias;     // y of the same item, delayed.

  modport src (
    output valid,
    output result,
    output tag,
    output op2,
    output op2_mod,
    output bias
  );

  modport dst (
    input valid,
    input result,
    input tag,
    input op2,
    input op2_mod,
    input bias
  );

endinterface

//--- ce_delay_pipe.sv
module ce_delay_pipe #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 1
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     en_i,
  input  logic     flush_i,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o,
  output logic     busy_o
);

  logic [DEPTH-1:0] valid_q;
  payload_t         data_q [DEPTH];

  // stage i takes its input from chain position i.
  logic [DEPTH:0] valid_chain;
  payload_t       data_chain [DEPTH+1];

  assign valid_chain = {valid_q, valid_i};

  always_comb begin
    data_chain[0] = data_i;
    for (int i = 0; i < DEPTH; i++) begin
      data_chain[i+1] = data_q[i];
    end
  end

  for (genvar i = 0; i < DEPTH; i++) begin : g_stage
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        valid_q[i] <= 1'b0;
        data_q[i]  <= '0;
      end else if (flush_i) begin
        valid_q[i] <= 1'b0;  // flush wins over a stall.
      end else if (en_i) begin
        valid_q[i] <= valid_chain[i];
        if (valid_chain[i]) data_q[i] <= data_chain[i];  // only real items move data.
      end
    end
  end

  assign valid_o = valid_q[DEPTH-1];
  assign data_o  = data_q[DEPTH-1];
  assign busy_o  = |valid_q;

  // nothing may leave the pipe right after a flush.
  a_flush_clears : assert property (
    @(posedge clk_i) disable iff (!rst_ni) flush_i |=> !valid_o
  );

endmodule

//--- ce_stage1.sv
`include "ce_params.svh"

module ce_stage1 (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  ce_pkg::data_t x_i,
  input  ce_pkg::data_t w_i,
  input  ce_pkg::data_t y_i,
  input  ce_pkg::op1_e  op1_i,
  input  logic          op1_mod_i,
  input  ce_pkg::op2_e  op2_i,
  input  logic          op2_mod_i,
  input  ce_pkg::tag_t  tag_i,
  input  logic          valid_i,
  input  logic          en_i,
  input  logic          flush_i,
  ce_stage_if.src       out,
  output logic          busy_o
);

  import ce_pkg::*;

  wide_t prod_term;   // product after the q-format shift, or x for add.
  data_t addend;
  data_t mm_d;

  // first register.
  logic  v1_q;
  wide_t prod_q;
  data_t addend_q;
  op1_e  op1_q;
  data_t mm_q;

  // second register.
  logic  v2_q;
  data_t res_q;
  wide_t sum;

  side_t side_d;
  side_t side_q;

  // operand routing.
  always_comb begin
    prod_term = (wide_t'(x_i) * wide_t'(w_i)) >>> `CE_FRAC_W;
    addend    = y_i;
    case (op1_i)
      OP1_MUL: addend = '0;  // bias is ignored.
      OP1_ADD: begin
        prod_term = wide_t'(x_i);  // x and w take the addend positions.
        addend    = w_i;
      end
      default: ;
    endcase
  end

  assign mm_d = min_max(x_i, w_i, op1_mod_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      v1_q <= 1'b0;
      v2_q <= 1'b0;
    end else if (flush_i) begin
      v1_q <= 1'b0;
      v2_q <= 1'b0;
    end else if (en_i) begin
      v1_q <= valid_i;
      v2_q <= v1_q;
    end
  end

  // datapath registers load only with an item.
  always_ff @(posedge clk_i) begin
    if (en_i && !flush_i && valid_i) begin
      prod_q   <= prod_term;
      addend_q <= addend;
      op1_q    <= op1_i;
      mm_q     <= mm_d;
    end
  end

  assign sum = prod_q + wide_t'(addend_q);

  always_ff @(posedge clk_i) begin
    if (en_i && !flush_i && v1_q) begin
      res_q <= (op1_q == OP1_MINMAX) ? mm_q : sat_data(sum);
    end
  end

  assign side_d.tag     = tag_i;
  assign side_d.op2     = op2_i;
  assign side_d.op2_mod = op2_mod_i;
  assign side_d.bias    = y_i;

  ce_delay_pipe #(
    .payload_t (side_t),
    .DEPTH     (`CE_S1_DEPTH)
  ) side_pipe_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .en_i    (en_i),
    .flush_i (flush_i),
    .valid_i (valid_i),
    .data_i  (side_d),
    .valid_o (),
    .data_o  (side_q),
    .busy_o  ()
  );

  assign out.valid   = v2_q;
  assign out.result  = res_q;
  assign out.tag     = side_q.tag;
  assign out.op2     = side_q.op2;
  assign out.op2_mod = side_q.op2_mod;
  assign out.bias    = side_q.bias;

  assign busy_o = v1_q | v2_q;

  a_op1_known : assert property (
    @(posedge clk_i) disable iff (!rst_ni) valid_i |-> !$isunknown(op1_i)
  );

endmodule

//--- ce_stage2.sv
module ce_stage2 (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          en_i,
  input  logic          flush_i,
  ce_stage_if.dst       in,
  output ce_pkg::data_t z_o,
  output ce_pkg::tag_t  tag_o,
  output logic          valid_o,
  output logic          busy_o
);

  import ce_pkg::*;

  out_t out_d;
  out_t out_q;

  // second min/max against the delayed bias, or pass-through.
  always_comb begin
    out_d.tag = in.tag;
    if (in.op2 == OP2_MINMAX) begin
      out_d.result = min_max(in.result, in.bias, in.op2_mod);
    end else begin
      out_d.result = in.result;
    end
  end

  // output register.
  ce_delay_pipe #(
    .payload_t (out_t),
    .DEPTH     (1)
  ) out_reg_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .en_i    (en_i),
    .flush_i (flush_i),
    .valid_i (in.valid),
    .data_i  (out_d),
    .valid_o (valid_o),
    .data_o  (out_q),
    .busy_o  (busy_o)
  );

  assign z_o   = out_q.result;
  assign tag_o = out_q.tag;

  a_z_known : assert property (
    @(posedge clk_i) disable iff (!rst_ni) valid_o |-> !$isunknown(z_o)
  );

endmodule

//--- ce_top.sv
module ce_top (
  input  logic          stage2_noncomp_input_pipe_clk,
  input  logic          rst_ni,
  input  ce_pkg::data_t x_i,
  input  ce_pkg::data_t w_i,
  input  ce_pkg::data_t y_i,        // bias.
  input  ce_pkg::op1_e  op1_i,
  input  logic          op1_mod_i,
  input  ce_pkg::op2_e  op2_i,
  input  logic          op2_mod_i,
  input  ce_pkg::tag_t  tag_i,
  input  logic          in_valid_i,
  input  logic          reg_enable_i,  // low stalls the whole element.
  input  logic          flush_i,
  output ce_pkg::data_t z_o,
  output ce_pkg::tag_t  tag_o,
  output logic          out_valid_o,
  output logic          busy_o
);

  import ce_pkg::*;

  logic s1_busy;
  logic s2_busy;

  ce_stage_if s1_to_s2 ();

  ce_stage1 stage1_i (
    .clk_i     (stage2_noncomp_input_pipe_clk),
    .rst_ni    (rst_ni),
    .x_i       (x_i),
    .w_i       (w_i),
    .y_i       (y_i),
    .op1_i     (op1_i),
    .op1_mod_i (op1_mod_i),
    .op2_i     (op2_i),
    .op2_mod_i (op2_mod_i),
    .tag_i     (tag_i),
    .valid_i   (in_valid_i),
    .en_i      (reg_enable_i),
    .flush_i   (flush_i),
    .out       (s1_to_s2.src),
    .busy_o    (s1_busy)
  );

  ce_stage2 stage2_i (
    .clk_i   (stage2_noncomp_input_pipe_clk),
    .rst_ni  (rst_ni),
    .en_i    (reg_enable_i),
    .flush_i (flush_i),
    .in      (s1_to_s2.dst),
    .z_o     (z_o),
    .tag_o   (tag_o),
    .valid_o (out_valid_o),
    .busy_o  (s2_busy)
  );

  assign busy_o = s1_busy | s2_busy;

endmodule

//--- tb_ce.sv
`include "ce_params.svh"

module tb_ce;

  timeunit 1ns;
  timeprecision 100ps;

  import ce_pkg::*;

  localparam int N_RAND    = 40;  // items per op1 in the random test.
  localparam int N_DIR     = 6;
  localparam int N_MM      = 20;
  localparam int N_OP2     = 8;   // items per op1 and mode pair.
  localparam int N_STALL   = 100;
  localparam int MAX_STALL = 4;
  localparam int N_FLUSH   = 40;
  localparam int DRAIN     = 10;  // allowance for each drain.
  localparam int STIM_CYCLES = 2 + 3 * N_RAND + N_DIR + 2 * N_MM + 8 * N_OP2
                             + N_STALL * (1 + MAX_STALL) + N_FLUSH + 8 * DRAIN;
  localparam int LIMIT = 4 * STIM_CYCLES;
  localparam int LAT   = `CE_S1_DEPTH + 1;  // enabled edges, acceptance edge included.
  localparam longint SCALE = longint'(1) << `CE_FRAC_W;
  localparam data_t P_BIG = 16'sh7fff;
  localparam data_t N_BIG = -16'sh7fff;

  logic  stage2_noncomp_input_pipe_clk = 1'b0;
  logic  rst_ni;
  data_t x_i;
  data_t w_i;
  data_t y_i;
  op1_e  op1_i;
  logic  op1_mod_i;
  op2_e  op2_i;
  logic  op2_mod_i;
  tag_t  tag_i;
  logic  in_valid_i;
  logic  reg_enable_i;
  logic  flush_i;
  data_t z_o;
  tag_t  tag_o;
  logic  out_valid_o;
  logic  busy_o;

  // expected items, oldest first.
  data_t exp_z_q [$];
  tag_t  exp_tag_q [$];
  int    stamp_q [$];
  string name_q [$];

  data_t exp_z;
  tag_t  exp_tag;
  int    exp_stamp;
  string exp_name;
  int    en_edges = 0;
  logic  last_edge_en = 1'b0;  // the previous edge moved the pipe.
  int    errors = 0;
  int    checks = 0;
  int    cycles = 0;
  int    seed = 76968;
  tag_t  next_tag = '0;
  string test_name = "reset";

  ce_top ce_top_i (.*);

  always #2 stage2_noncomp_input_pipe_clk = ~stage2_noncomp_input_pipe_clk;

  function automatic data_t clamp_q88(input longint v);
    longint hi;
    longint lo;
    hi = (longint'(1) << (`CE_DATA_W - 1)) - 1;
    lo = -hi - 1;
    if (v > hi) return data_t'(hi);
    if (v < lo) return data_t'(lo);
    return data_t'(v);
  endfunction

  function automatic data_t pick_extreme(input data_t a, input data_t b, input logic take_max);
    if (take_max) return (a >= b) ? a : b;
    return (a <= b) ? a : b;
  endfunction

  function automatic data_t ce_ref(input data_t x, input data_t w, input data_t y,
                                   input op1_e op1, input logic m1,
                                   input op2_e op2, input logic m2);
    longint prod;
    longint acc;
    data_t  r;
    prod = longint'(x) * longint'(w);
    if (prod < 0) prod = -((-prod + SCALE - 1) / SCALE);  // floor, not toward zero.
    else prod = prod / SCALE;
    case (op1)
      OP1_FMA: acc = prod + longint'(y);
      OP1_MUL: acc = prod;
      OP1_ADD: acc = longint'(x) + longint'(w);
      default: acc = longint'(pick_extreme(x, w, m1));
    endcase
    r = clamp_q88(acc);
    if (op2 == OP2_MINMAX) r = pick_extreme(r, y, m2);  // against the same item's bias.
    return r;
  endfunction

  // half of the operands stay within +-4.0 so that not every product saturates.
  function automatic data_t rand_operand();
    int r;
    r = $random(seed);
    if (r[0]) return data_t'(r >>> 16);
    return data_t'((r >>> 8) % 1024);
  endfunction

  task automatic send_item(input data_t x, input data_t w, input data_t y, input op1_e op1,
                           input logic m1, input op2_e op2, input logic m2, input int stall);
    @(posedge stage2_noncomp_input_pipe_clk);
    x_i          <= x;
    w_i          <= w;
    y_i          <= y;
    op1_i        <= op1;
    op1_mod_i    <= m1;
    op2_i        <= op2;
    op2_mod_i    <= m2;
    tag_i        <= next_tag;
    in_valid_i   <= 1'b1;
    reg_enable_i <= (stall == 0);
    next_tag++;
    for (int i = 0; i < stall; i++) begin
      @(posedge stage2_noncomp_input_pipe_clk);
      if (i == stall - 1) reg_enable_i <= 1'b1;  // item is taken at the next edge.
    end
  endtask

  task automatic go_idle();
    @(posedge stage2_noncomp_input_pipe_clk);
    in_valid_i   <= 1'b0;
    reg_enable_i <= 1'b1;
    flush_i      <= 1'b0;
  endtask

  task automatic wait_drain();
    go_idle();
    @(negedge stage2_noncomp_input_pipe_clk);
    while (busy_o) @(negedge stage2_noncomp_input_pipe_clk);
    assert (!out_valid_o && exp_z_q.size() == 0) else begin
      $display("Test %s lost %0d items, the pipe drained without them",
               test_name, exp_z_q.size());
      errors++;
      exp_z_q.delete();
      exp_tag_q.delete();
      stamp_q.delete();
      name_q.delete();
    end
  endtask

  // a new item rides in beside the flush and must be dropped as well.
  task automatic flush_pipe(input logic stalled);
    @(posedge stage2_noncomp_input_pipe_clk);
    tag_i        <= next_tag;
    flush_i      <= 1'b1;
    reg_enable_i <= !stalled;
    next_tag++;
    @(posedge stage2_noncomp_input_pipe_clk);
    flush_i      <= 1'b0;
    in_valid_i   <= 1'b0;
    reg_enable_i <= 1'b1;
    @(negedge stage2_noncomp_input_pipe_clk);
    assert (!busy_o && !out_valid_o) else begin
      $display("Flush in test %s left items in the pipe", test_name);
      errors++;
    end
    repeat (4) begin
      @(negedge stage2_noncomp_input_pipe_clk);
      assert (!out_valid_o) else begin
        $display("An output appeared after the flush in test %s", test_name);
        errors++;
      end
    end
  endtask

  // scoreboard side, sampled at the edge that the DUT sees.
  always @(posedge stage2_noncomp_input_pipe_clk) begin
    if (rst_ni) begin
      last_edge_en = reg_enable_i;
      if (reg_enable_i) en_edges++;
      if (flush_i) begin
        exp_z_q.delete();
        exp_tag_q.delete();
        stamp_q.delete();
        name_q.delete();
      end else if (in_valid_i && reg_enable_i) begin
        exp_z_q.push_back(ce_ref(x_i, w_i, y_i, op1_i, op1_mod_i, op2_i, op2_mod_i));
        exp_tag_q.push_back(tag_i);
        stamp_q.push_back(en_edges);
        name_q.push_back(test_name);
      end
    end
  end

  // an output held through a stall counts once.
  always @(negedge stage2_noncomp_input_pipe_clk) begin
    if (rst_ni && out_valid_o && last_edge_en) begin
      if (exp_z_q.size() == 0) begin
        $display("Output with tag %0d appeared while no item was expected", tag_o);
        errors++;
      end else begin
        exp_z     = exp_z_q.pop_front();
        exp_tag   = exp_tag_q.pop_front();
        exp_stamp = stamp_q.pop_front();
        exp_name  = name_q.pop_front();
        checks++;
        assert (z_o == exp_z) else begin
          $display("Error %s expected %0d actual %0d", exp_name, exp_z, z_o);
          errors++;
        end
        assert (tag_o == exp_tag) else begin
          $display("Error %s tag expected %0d actual %0d", exp_name, exp_tag, tag_o);
          errors++;
        end
        assert (en_edges - exp_stamp + 1 == LAT) else begin
          $display("Error %s latency expected %0d actual %0d",
                   exp_name, LAT, en_edges - exp_stamp + 1);
          errors++;
        end
      end
    end
  end

  always @(posedge stage2_noncomp_input_pipe_clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("Timeout after %0d cycles, the run did not finish", cycles);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    int r;
    int stall;
    rst_ni       = 1'b0;
    x_i          = '0;
    w_i          = '0;
    y_i          = '0;
    op1_i        = OP1_FMA;
    op1_mod_i    = 1'b0;
    op2_i        = OP2_NONE;
    op2_mod_i    = 1'b0;
    tag_i        = '0;
    in_valid_i   = 1'b0;
    reg_enable_i = 1'b1;
    flush_i      = 1'b0;
    repeat (2) @(posedge stage2_noncomp_input_pipe_clk);
    rst_ni <= 1'b1;
    @(negedge stage2_noncomp_input_pipe_clk);
    assert (!out_valid_o && !busy_o && z_o == '0 && tag_o == '0) else begin
      $display("Outputs are not idle and zero after reset");
      errors++;
    end

    test_name = "random_ops";
    for (int k = 0; k < 3; k++) begin
      for (int n = 0; n < N_RAND; n++) begin
        send_item(rand_operand(), rand_operand(), rand_operand(), op1_e'(k[1:0]),
                  1'b0, OP2_NONE, 1'b0, 0);
      end
    end
    test_name = "saturation";
    send_item(P_BIG, P_BIG, P_BIG, OP1_FMA, 1'b0, OP2_NONE, 1'b0, 0);
    send_item(P_BIG, N_BIG, N_BIG, OP1_FMA, 1'b0, OP2_NONE, 1'b0, 0);
    send_item(P_BIG, P_BIG, '0, OP1_MUL, 1'b0, OP2_NONE, 1'b0, 0);
    send_item(N_BIG, P_BIG, 16'sd5, OP1_MUL, 1'b0, OP2_NONE, 1'b0, 0);
    send_item(P_BIG, P_BIG, '0, OP1_ADD, 1'b0, OP2_NONE, 1'b0, 0);
    send_item(N_BIG, N_BIG, '0, OP1_ADD, 1'b0, OP2_NONE, 1'b0, 0);
    wait_drain();

    test_name = "op1_minmax";
    for (int m = 0; m < 2; m++) begin
      for (int n = 0; n < N_MM; n++) begin
        send_item(rand_operand(), rand_operand(), rand_operand(), OP1_MINMAX,
                  m[0], OP2_NONE, 1'b0, 0);
      end
    end
    wait_drain();

    test_name = "op2_minmax";
    for (int k = 0; k < 4; k++) begin
      for (int m = 0; m < 2; m++) begin
        for (int n = 0; n < N_OP2; n++) begin
          send_item(rand_operand(), rand_operand(), rand_operand(), op1_e'(k[1:0]),
                    n[0], OP2_MINMAX, m[0], 0);
        end
      end
    end
    wait_drain();

    test_name = "stalls";
    for (int n = 0; n < N_STALL; n++) begin
      r = $random(seed);
      stall = (r[1:0] == 2'b00) ? int'(r[3:2]) + 1 : 0;
      send_item(rand_operand(), rand_operand(), rand_operand(), op1_e'(r[5:4]),
                r[6], op2_e'(r[7]), r[8], stall);
    end
    wait_drain();

    test_name = "flush";
    repeat (3) send_item(rand_operand(), rand_operand(), rand_operand(), OP1_FMA,
                         1'b0, OP2_NONE, 1'b0, 0);
    flush_pipe(1'b0);
    repeat (2) send_item(rand_operand(), rand_operand(), rand_operand(), OP1_ADD,
                         1'b0, OP2_MINMAX, 1'b1, 0);
    flush_pipe(1'b1);
    repeat (10) send_item(rand_operand(), rand_operand(), rand_operand(), OP1_MUL,
                          1'b0, OP2_MINMAX, 1'b0, 0);
    wait_drain();

    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) $display("No errors");
    else $display("Errors found");
    $finish;
  end

endmodule

//--- project.f
+incdir+.
ce_pkg.sv
ce_stage_if.sv
ce_delay_pipe.sv
ce_stage1.sv
ce_stage2.sv
ce_top.sv
tb_ce.sv

//--- Makefile
# verilator flow for the compute element testbench.

TOP = tb_ce

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir

# pass only if the pass message shows up in the simulation output.
run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
